// ==== project.f ====
+incdir+logic
logic/ctl_pkg.sv
logic/opcode_decoder.sv
logic/ctl_sequencer.sv
logic/ab_mode_decoder.sv
logic/datapath_op_decoder.sv
logic/ctl_top.sv
verification/tb_ctl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module tb_ctl -o tb_ctl \
    && ./obj_dir/tb_ctl > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^RESULT: PASS$" sim.log 2>/dev/null && exit 0 || exit 1

// ==== verification/tb_ctl.sv ====
// Testbench for the control unit of the 65C02-style core
// Runs a random instruction stream through ctl_top and keeps a cycle model of
// instruction length, JSR pushes, register loads and branch address words.
// Concurrent assertions compare the DUT outputs with the model every cycle.
`default_nettype none
`include "ctl_settings.svh"

module tb_ctl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_INSTR      = 400;
    localparam int MAX_LEN      = 5;                 // Longest instruction in cycles
    localparam int WATCHDOG_NS  = (RESET_CYCLES + N_INSTR * MAX_LEN) * CLK_PERIOD + 400;

    logic                     clk;
    logic                     rst_n;
    logic [`CTL_DB_W-1:0]     db   = '0;
    logic                     cond = 1'b0;
    wire                      sync;
    wire                      we;
    wire [`CTL_AB_OP_W-1:0]   ab_op;
    wire [`CTL_ALU_OP_W-1:0]  alu_op;
    wire [`CTL_REG_OP_W-1:0]  reg_op;
    wire [`CTL_DO_OP_W-1:0]   do_op;

    // Model of the current cycle
    logic [31:0]              rng_state = 32'h06c6920e;
    logic                     active    = 1'b0;      // Past reset and INIT
    logic                     rst_seen  = 1'b0;
    logic [7:0]               op_cur    = '0;
    int                       pos       = 0;         // Cycle index, 0 is the fetch
    int                       instr_cnt = 0;
    logic                     prev_ld   = 1'b0;      // Last instruction was a load
    logic [6:0]               exp_reg   = '0;
    logic                     exp_sync  = 1'b0;
    logic                     exp_we    = 1'b0;
    logic [1:0]               exp_do    = `CTL_DO_ALU;
    logic                     alu_chk   = 1'b0;
    logic [8:0]               exp_alu   = '0;
    logic                     ab_chk    = 1'b0;
    logic [11:0]              exp_ab    = '0;

    ctl_top i_dut (
        .clk(clk), .rst_n(rst_n), .db(db), .cond(cond),
        .sync(sync), .we(we), .ab_op(ab_op), .alu_op(alu_op),
        .reg_op(reg_op), .do_op(do_op)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Cycles from one fetch to the next
    function automatic int instr_len(input logic [7:0] op);
        case (op)
            `CTL_OPC_LDA_IMM, `CTL_OPC_LDX_IMM, `CTL_OPC_LDY_IMM,
            `CTL_OPC_BRA:                                          return 2;
            `CTL_OPC_LDA_ZP, `CTL_OPC_LDA_ZPX, `CTL_OPC_LDX_ZPY,
            `CTL_OPC_PHA, `CTL_OPC_PLA, `CTL_OPC_JMP_ABS:          return 3;
            `CTL_OPC_ASL_ZP, `CTL_OPC_ASL_ZPX, `CTL_OPC_LDA_ABS,
            `CTL_OPC_LDA_ABSX, `CTL_OPC_LDA_ABSY, `CTL_OPC_RTS:    return 4;
            `CTL_OPC_LDA_INDX, `CTL_OPC_LDA_IND, `CTL_OPC_LDA_INDY,
            `CTL_OPC_JMP_IND, `CTL_OPC_JMP_INDX, `CTL_OPC_JSR:     return 5;
            default:                                               return 1;
        endcase
    endfunction

    function automatic logic is_load(input logic [7:0] op);
        case (op)
            `CTL_OPC_LDA_IMM, `CTL_OPC_LDX_IMM, `CTL_OPC_LDY_IMM,
            `CTL_OPC_LDA_ZP, `CTL_OPC_LDA_ZPX, `CTL_OPC_LDX_ZPY,
            `CTL_OPC_LDA_ABS, `CTL_OPC_LDA_ABSX, `CTL_OPC_LDA_ABSY,
            `CTL_OPC_LDA_INDX, `CTL_OPC_LDA_IND, `CTL_OPC_LDA_INDY: return 1'b1;
            default:                                                return 1'b0;
        endcase
    endfunction

    function automatic logic [1:0] load_dst(input logic [7:0] op);
        case (op)
            `CTL_OPC_LDX_IMM, `CTL_OPC_LDX_ZPY: return `CTL_DST_X;
            `CTL_OPC_LDY_IMM:                   return `CTL_DST_Y;
            default:                            return `CTL_DST_A;
        endcase
    endfunction

    function automatic logic is_imm_load(input logic [7:0] op);
        return (op == `CTL_OPC_LDA_IMM) || (op == `CTL_OPC_LDX_IMM) ||
               (op == `CTL_OPC_LDY_IMM);
    endfunction

    function automatic logic [7:0] kept_opcode(input int idx);
        case (idx)
            0:  return `CTL_OPC_LDA_IMM;
            1:  return `CTL_OPC_LDX_IMM;
            2:  return `CTL_OPC_LDY_IMM;
            3:  return `CTL_OPC_LDA_ZP;
            4:  return `CTL_OPC_LDA_ZPX;
            5:  return `CTL_OPC_LDX_ZPY;
            6:  return `CTL_OPC_LDA_ABS;
            7:  return `CTL_OPC_LDA_ABSX;
            8:  return `CTL_OPC_LDA_ABSY;
            9:  return `CTL_OPC_LDA_INDX;
            10: return `CTL_OPC_LDA_IND;
            11: return `CTL_OPC_LDA_INDY;
            12: return `CTL_OPC_ASL_ZP;
            13: return `CTL_OPC_ASL_ZPX;
            14: return `CTL_OPC_JMP_ABS;
            15: return `CTL_OPC_JMP_IND;
            16: return `CTL_OPC_JMP_INDX;
            17: return `CTL_OPC_JSR;
            18: return `CTL_OPC_RTS;
            19: return `CTL_OPC_PHA;
            20: return `CTL_OPC_PLA;
            default: return `CTL_OPC_BRA;
        endcase
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        wait (instr_cnt >= N_INSTR);
        repeat (MAX_LEN + 1) @(posedge clk);        // Let the last checks sample
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the instruction stream did not complete in time");
        abort_run();
    end

    // Stimulus and model, one step per clock
    always @(posedge clk) begin
        logic [31:0] r;
        logic [7:0]  op_n;
        logic [7:0]  db_n;
        logic        cond_n;
        int          pos_n;
        r      = next_rand();
        db_n   = r[7:0];                             // Operand bytes are random
        cond_n = r[8];
        op_n   = op_cur;
        pos_n  = pos + 1;
        if (!rst_n) begin
            rst_seen <= 1'b1;
            active   <= 1'b0;
            prev_ld  <= 1'b0;
        end else begin
            if (!active || pos + 1 >= instr_len(op_cur)) begin
                r     = next_rand();
                op_n  = (r[2:0] == 3'd0) ? r[15:8] : kept_opcode(int'(r[31:16]) % 22);
                db_n  = op_n;                        // Opcode on the fetch cycle
                pos_n = 0;
                if (active) begin
                    prev_ld <= is_load(op_cur);
                    exp_reg <= {1'b1, load_dst(op_cur), `CTL_SRC_Z};
                end
                instr_cnt <= instr_cnt + 1;
            end
            active   <= 1'b1;
            op_cur   <= op_n;
            pos      <= pos_n;
            exp_sync <= (pos_n == 0);
            exp_we   <= (op_n == `CTL_OPC_JSR) && (pos_n == 2 || pos_n == 3);
            if (op_n == `CTL_OPC_JSR && pos_n == 2)
                exp_do <= `CTL_DO_PCH;
            else if (op_n == `CTL_OPC_JSR && pos_n == 3)
                exp_do <= `CTL_DO_PCL;
            else
                exp_do <= `CTL_DO_ALU;
            alu_chk <= 1'b1;
            if (pos_n == 0)
                exp_alu <= `CTL_ALU_ADD;
            else if (op_n == `CTL_OPC_JSR && (pos_n == 1 || pos_n == 2))
                exp_alu <= `CTL_ALU_DEC;             // Two stack pushes
            else if (is_imm_load(op_n) && pos_n == 1)
                exp_alu <= `CTL_ALU_LOAD_M;
            else
                alu_chk <= 1'b0;
            ab_chk <= (op_n == `CTL_OPC_BRA) && (pos_n == 1);
            exp_ab <= (cond_n && db_n[7]) ? `CTL_AB_OP_BACK : `CTL_AB_OP_FWD;
        end
        db   <= db_n;
        cond <= cond_n;
    end

    a_reset_we: assert property (@(posedge clk) rst_seen && !rst_n |-> we == 1'b0)
        else begin
            $display("FAILED we in reset: got %h expected 0", $sampled(we));
            abort_run();
        end

    a_sync: assert property (@(posedge clk) active |-> sync == exp_sync)
        else begin
            $display("FAILED sync: got %h expected %h", $sampled(sync), $sampled(exp_sync));
            abort_run();
        end

    a_we: assert property (@(posedge clk) active |-> we == exp_we)
        else begin
            $display("FAILED we: got %h expected %h", $sampled(we), $sampled(exp_we));
            abort_run();
        end

    a_do_op: assert property (@(posedge clk) active |-> do_op == exp_do)
        else begin
            $display("FAILED do_op: got %h expected %h", $sampled(do_op), $sampled(exp_do));
            abort_run();
        end

    a_alu_op: assert property (@(posedge clk) active && alu_chk |-> alu_op == exp_alu)
        else begin
            $display("FAILED alu_op: got %h expected %h", $sampled(alu_op),
                     $sampled(exp_alu));
            abort_run();
        end

    a_reg_load: assert property (@(posedge clk)
        active && exp_sync && prev_ld |-> reg_op == exp_reg)
        else begin
            $display("FAILED reg_op: got %h expected %h", $sampled(reg_op),
                     $sampled(exp_reg));
            abort_run();
        end

    a_reg_no_load: assert property (@(posedge clk)
        active && exp_sync && !prev_ld |-> reg_op[6] == 1'b0)
        else begin
            $display("FAILED reg_op: got %h expected write bit 0", $sampled(reg_op));
            abort_run();
        end

    a_ab_op: assert property (@(posedge clk) active && ab_chk |-> ab_op == exp_ab)
        else begin
            $display("FAILED ab_op: got %h expected %h", $sampled(ab_op), $sampled(exp_ab));
            abort_run();
        end

endmodule

`default_nettype wire

// ==== logic/ctl_top.sv ====
// Control unit of the 65C02-style core
// Sequencer plus opcode, address-bus and datapath decoders
`default_nettype none
`include "ctl_settings.svh"

module ctl_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [`CTL_DB_W-1:0]      db,
    input  wire                      cond,
    output logic                     sync,
    output logic                     we,
    output logic [`CTL_AB_OP_W-1:0]  ab_op,
    output logic [`CTL_ALU_OP_W-1:0] alu_op,
    output logic [`CTL_REG_OP_W-1:0] reg_op,
    output logic [`CTL_DO_OP_W-1:0]  do_op
);

    ctl_pkg::state_t state;
    ctl_pkg::state_t entry_state;
    logic            rmw, jmp, ind;                      // Sequencing flags
    logic            add_x, add_y, ld;                   // Datapath flags
    logic [1:0]      dst;

    opcode_decoder i_opcode_decoder (
        .clk(clk), .rst_n(rst_n), .db(db), .state(state),
        .rmw(rmw), .jmp(jmp), .ind(ind), .add_x(add_x), .add_y(add_y),
        .ld(ld), .dst(dst), .entry_state(entry_state)
    );

    ctl_sequencer i_ctl_sequencer (
        .clk(clk), .rst_n(rst_n), .entry_state(entry_state),
        .rmw(rmw), .jmp(jmp), .ind(ind),
        .state(state), .sync(sync), .we(we)
    );

    ab_mode_decoder i_ab_mode_decoder (
        .state(state), .cond(cond), .db(db), .ab_op(ab_op)
    );

    datapath_op_decoder i_datapath_op_decoder (
        .state(state), .add_x(add_x), .add_y(add_y), .ld(ld), .dst(dst),
        .alu_op(alu_op), .reg_op(reg_op), .do_op(do_op)
    );

endmodule

`default_nettype wire

// ==== logic/datapath_op_decoder.sv ====
// Datapath control decoder
// ALU operation, register transfer and data-out select for each state
`default_nettype none
`include "ctl_settings.svh"

module datapath_op_decoder (
    input  wire ctl_pkg::state_t     state,
    input  wire                      add_x,
    input  wire                      add_y,
    input  wire                      ld,
    input  wire [1:0]                dst,
    output logic [`CTL_ALU_OP_W-1:0] alu_op,
    output logic [`CTL_REG_OP_W-1:0] reg_op,
    output logic [`CTL_DO_OP_W-1:0]  do_op
);

    // Index register feeding the address adder, Z when not indexed
    function automatic logic [3:0] idx_src(input logic use_x, input logic use_y);
        if (use_x)
            return `CTL_SRC_X;
        else if (use_y)
            return `CTL_SRC_Y;
        return `CTL_SRC_Z;
    endfunction

    always_comb begin
        case (state)
            ctl_pkg::JSR0,
            ctl_pkg::JSR1: alu_op = `CTL_ALU_DEC;        // S - 1 per push
            ctl_pkg::RTS0,
            ctl_pkg::RTS1: alu_op = `CTL_ALU_INC;        // S + 1 per pull
            ctl_pkg::IMM0,
            ctl_pkg::BACK: alu_op = `CTL_ALU_LOAD_M;
            ctl_pkg::SYNC: alu_op = `CTL_ALU_ADD;        // Result of previous load
            default:       alu_op = '0;
        endcase
    end

    always_comb begin
        case (state)
            ctl_pkg::JSR0,
            ctl_pkg::JSR1,
            ctl_pkg::RTS0,
            ctl_pkg::RTS1: reg_op = {1'b1, `CTL_DST_S, `CTL_SRC_S};
            ctl_pkg::IND0: reg_op = {1'b0, `CTL_DST_X, idx_src(add_x, 1'b0)};  // (zp,x)
            ctl_pkg::IND2: reg_op = {1'b0, `CTL_DST_X, idx_src(1'b0, add_y)};  // (zp),y
            ctl_pkg::ZERO,
            ctl_pkg::ABS1: reg_op = {1'b0, `CTL_DST_X, idx_src(add_x, add_y)};
            ctl_pkg::SYNC: reg_op = {ld, dst, `CTL_SRC_Z};                     // dst <= Z op M
            default:       reg_op = {1'b0, `CTL_DST_X, `CTL_SRC_Z};
        endcase
    end

    always_comb begin
        case (state)
            ctl_pkg::JSR1: do_op = `CTL_DO_PCH;          // High byte pushed first
            ctl_pkg::JSR2: do_op = `CTL_DO_PCL;
            default:       do_op = `CTL_DO_ALU;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ab_mode_decoder.sv ====
// Address-bus control decoder
// Picks an address mode for the current state and expands it into
// the PC, AHL and ABH/ABL controls of the address datapath
`default_nettype none
`include "ctl_settings.svh"

module ab_mode_decoder (
    input  wire ctl_pkg::state_t    state,
    input  wire                     cond,
    input  wire [`CTL_DB_W-1:0]     db,
    output logic [`CTL_AB_OP_W-1:0] ab_op
);

    ctl_pkg::ab_mode_t mode;
    logic [1:0]        abl_sel;
    logic              abl_ci;
    logic              back;

    assign abl_sel = mode[1:0];
    assign abl_ci  = mode[2];
    assign back    = cond & db[7];                       // Taken with a negative offset

    always_comb begin
        case (state)
            ctl_pkg::INIT: mode = ctl_pkg::AB_KEEP;
            ctl_pkg::RDWR: mode = ctl_pkg::AB_KEEP;      // Hold address for write
            ctl_pkg::BACK: mode = ctl_pkg::AB_PC;
            ctl_pkg::JSR2: mode = ctl_pkg::AB_PC;
            ctl_pkg::SYNC: mode = ctl_pkg::AB_INC_STORE_PC;
            ctl_pkg::IMM0: mode = ctl_pkg::AB_INC_STORE_PC;
            ctl_pkg::ABS0: mode = ctl_pkg::AB_INC_STORE_PC;
            ctl_pkg::ABS1: mode = ctl_pkg::AB_ABS_STORE_PC;
            ctl_pkg::ZERO: mode = ctl_pkg::AB_ZP_INDEX;
            ctl_pkg::IND0: mode = ctl_pkg::AB_ZP_INDEX;
            ctl_pkg::IND1: mode = ctl_pkg::AB_INC_KEEP_PC;
            ctl_pkg::IND2: mode = ctl_pkg::AB_ABS_KEEP_PC;
            ctl_pkg::PULL: mode = ctl_pkg::AB_SP_INC;
            ctl_pkg::RTS0: mode = ctl_pkg::AB_SP_INC;
            ctl_pkg::RTS1: mode = ctl_pkg::AB_SP_INC;
            ctl_pkg::RTS2: mode = ctl_pkg::AB_ABS_INC;   // Return address + 1
            ctl_pkg::PUSH: mode = ctl_pkg::AB_SP;
            ctl_pkg::JSR0: mode = ctl_pkg::AB_SP_STORE_PC1;
            ctl_pkg::JSR1: mode = ctl_pkg::AB_SP_KEEP_PC;
            ctl_pkg::COND: mode = ctl_pkg::AB_BRANCH;
            default:       mode = ctl_pkg::AB_KEEP;
        endcase
    end

    // Upper seven bits drive PC, AHL and ABH; low bits come from the mode
    always_comb begin
        case (mode)
            ctl_pkg::AB_KEEP:         ab_op = {7'b001_0110, abl_sel, 2'b11, abl_ci};
            ctl_pkg::AB_PC:           ab_op = {7'b000_1010, abl_sel, 2'b10, abl_ci};
            ctl_pkg::AB_ABS_STORE_PC: ab_op = {7'b111_1110, abl_sel, 2'b01, abl_ci};
            ctl_pkg::AB_ZP_INDEX:     ab_op = {7'b111_0000, abl_sel, 2'b01, abl_ci};
            ctl_pkg::AB_INC_STORE_PC: ab_op = {7'b011_0110, abl_sel, 2'b11, abl_ci};
            ctl_pkg::AB_SP_INC:       ab_op = {7'b011_0001, abl_sel, 2'b00, abl_ci};
            ctl_pkg::AB_BRANCH:       ab_op = back ? `CTL_AB_OP_BACK : `CTL_AB_OP_FWD;
            ctl_pkg::AB_SP_KEEP_PC:   ab_op = {7'b000_0001, abl_sel, 2'b00, abl_ci};
            ctl_pkg::AB_SP_STORE_PC1: ab_op = {7'b111_0001, abl_sel, 2'b00, abl_ci};
            ctl_pkg::AB_ABS_KEEP_PC:  ab_op = {7'b001_1110, abl_sel, 2'b01, abl_ci};
            ctl_pkg::AB_SP:           ab_op = {7'b010_0001, abl_sel, 2'b00, abl_ci};
            ctl_pkg::AB_INC_KEEP_PC:  ab_op = {7'b001_0110, abl_sel, 2'b11, abl_ci};
            ctl_pkg::AB_ABS_INC:      ab_op = {7'b001_1110, abl_sel, 2'b01, abl_ci};
            default:                  ab_op = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ctl_sequencer.sv ====
// Control state machine
// Steps through the cycles of each instruction, one state per clock,
// flags the opcode fetch cycle and registers the bus write enable
`default_nettype none
`include "ctl_settings.svh"

module ctl_sequencer (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire ctl_pkg::state_t  entry_state,
    input  wire                   rmw,
    input  wire                   jmp,
    input  wire                   ind,
    output ctl_pkg::state_t       state,
    output logic                  sync,
    output logic                  we
);

    ctl_pkg::state_t state_nxt;

    assign sync = (state == ctl_pkg::SYNC);

    always_comb begin
        case (state)
            ctl_pkg::INIT: state_nxt = ctl_pkg::SYNC;
            ctl_pkg::SYNC: state_nxt = entry_state;      // From opcode on db
            ctl_pkg::IMM0: state_nxt = ctl_pkg::SYNC;
            ctl_pkg::COND: state_nxt = ctl_pkg::SYNC;
            ctl_pkg::ZERO: state_nxt = rmw ? ctl_pkg::RDWR : ctl_pkg::BACK;
            ctl_pkg::RDWR: state_nxt = ctl_pkg::BACK;
            ctl_pkg::PUSH: state_nxt = ctl_pkg::BACK;
            ctl_pkg::PULL: state_nxt = ctl_pkg::BACK;
            ctl_pkg::BACK: state_nxt = ctl_pkg::SYNC;
            ctl_pkg::ABS0: state_nxt = ctl_pkg::ABS1;
            ctl_pkg::ABS1: begin
                if (ind)
                    state_nxt = ctl_pkg::ABS0;           // Fetch target through pointer
                else if (jmp)
                    state_nxt = ctl_pkg::SYNC;
                else
                    state_nxt = ctl_pkg::BACK;
            end
            ctl_pkg::IND0: state_nxt = ctl_pkg::IND1;
            ctl_pkg::IND1: state_nxt = ctl_pkg::IND2;
            ctl_pkg::IND2: state_nxt = ctl_pkg::BACK;
            ctl_pkg::RTS0: state_nxt = ctl_pkg::RTS1;
            ctl_pkg::RTS1: state_nxt = ctl_pkg::RTS2;
            ctl_pkg::RTS2: state_nxt = ctl_pkg::SYNC;
            ctl_pkg::JSR0: state_nxt = ctl_pkg::JSR1;
            ctl_pkg::JSR1: state_nxt = ctl_pkg::JSR2;
            ctl_pkg::JSR2: state_nxt = ctl_pkg::ABS1;    // jmp set, ends in SYNC
            default:       state_nxt = ctl_pkg::SYNC;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ctl_pkg::INIT;
            we    <= 1'b0;
        end else begin
            state <= state_nxt;
            // Return address push, PCH then PCL
            we    <= (state == ctl_pkg::JSR0) || (state == ctl_pkg::JSR1);
        end
    end

endmodule

`default_nettype wire

// ==== logic/opcode_decoder.sv ====
// Opcode decoder
// Latches per-instruction flags from the opcode byte in the fetch cycle
// and gives the sequencer the first state of each instruction
`default_nettype none
`include "ctl_settings.svh"

module opcode_decoder (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [`CTL_DB_W-1:0]   db,
    input  wire ctl_pkg::state_t  state,
    output logic                  rmw,
    output logic                  jmp,
    output logic                  ind,
    output logic                  add_x,
    output logic                  add_y,
    output logic                  ld,
    output logic [1:0]            dst,
    output ctl_pkg::state_t       entry_state
);

    logic       rmw_d, jmp_d, ind_d, add_x_d, add_y_d, ld_d;   // Decoded from db
    logic [1:0] dst_d;
    logic       fetch;

    assign fetch = (state == ctl_pkg::SYNC);

    always_comb begin
        rmw_d   = 1'b0;
        jmp_d   = 1'b0;
        ind_d   = 1'b0;
        add_x_d = 1'b0;
        add_y_d = 1'b0;
        ld_d    = 1'b0;                                  // Non-loads never write
        dst_d   = `CTL_DST_A;
        case (db)
            `CTL_OPC_ASL_ZP:   rmw_d = 1'b1;
            `CTL_OPC_ASL_ZPX:  {rmw_d, add_x_d} = 2'b11;
            `CTL_OPC_JSR,
            `CTL_OPC_RTS,
            `CTL_OPC_JMP_ABS:  jmp_d = 1'b1;
            `CTL_OPC_JMP_IND:  {jmp_d, ind_d} = 2'b11;
            `CTL_OPC_JMP_INDX: {jmp_d, ind_d, add_x_d} = 3'b111;
            `CTL_OPC_LDA_IMM,
            `CTL_OPC_LDA_ZP,
            `CTL_OPC_LDA_ABS,
            `CTL_OPC_LDA_IND:  ld_d = 1'b1;
            `CTL_OPC_LDA_ZPX,
            `CTL_OPC_LDA_ABSX,
            `CTL_OPC_LDA_INDX: {ld_d, add_x_d} = 2'b11;
            `CTL_OPC_LDA_ABSY,
            `CTL_OPC_LDA_INDY: {ld_d, add_y_d} = 2'b11;
            `CTL_OPC_LDX_IMM: begin
                ld_d  = 1'b1;
                dst_d = `CTL_DST_X;
            end
            `CTL_OPC_LDX_ZPY: begin
                {ld_d, add_y_d} = 2'b11;
                dst_d = `CTL_DST_X;
            end
            `CTL_OPC_LDY_IMM: begin
                ld_d  = 1'b1;
                dst_d = `CTL_DST_Y;
            end
            default: ;                                   // All flags clear
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {rmw, jmp, ind, add_x, add_y, ld} <= '0;
            dst <= `CTL_DST_X;
        end else if (fetch) begin
            {rmw, jmp, ind, add_x, add_y, ld} <= {rmw_d, jmp_d, ind_d, add_x_d, add_y_d, ld_d};
            dst <= dst_d;
        end else if (state == ctl_pkg::ABS1) begin
            ind   <= 1'b0;                               // Indirection resolves once
            add_x <= 1'b0;                               // X used on pointer only
        end
    end

    always_comb begin
        case (db)
            `CTL_OPC_BRA:      entry_state = ctl_pkg::COND;
            `CTL_OPC_JSR:      entry_state = ctl_pkg::JSR0;
            `CTL_OPC_RTS:      entry_state = ctl_pkg::RTS0;
            `CTL_OPC_PHA:      entry_state = ctl_pkg::PUSH;
            `CTL_OPC_PLA:      entry_state = ctl_pkg::PULL;
            `CTL_OPC_LDA_IMM,
            `CTL_OPC_LDX_IMM,
            `CTL_OPC_LDY_IMM:  entry_state = ctl_pkg::IMM0;
            `CTL_OPC_ASL_ZP,
            `CTL_OPC_ASL_ZPX,
            `CTL_OPC_LDA_ZP,
            `CTL_OPC_LDA_ZPX,
            `CTL_OPC_LDX_ZPY:  entry_state = ctl_pkg::ZERO;
            `CTL_OPC_LDA_INDX,
            `CTL_OPC_LDA_IND,
            `CTL_OPC_LDA_INDY: entry_state = ctl_pkg::IND0;
            `CTL_OPC_JMP_ABS,
            `CTL_OPC_JMP_IND,
            `CTL_OPC_JMP_INDX,
            `CTL_OPC_LDA_ABS,
            `CTL_OPC_LDA_ABSX,
            `CTL_OPC_LDA_ABSY: entry_state = ctl_pkg::ABS0;
            default:           entry_state = ctl_pkg::SYNC;   // Unknown, fetch again
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ctl_pkg.sv ====
// Control sequencer types
// Sequencer states and the address-bus modes they select
`default_nettype none

package ctl_pkg;

    typedef enum logic [4:0] {
        INIT,                        // Out of reset
        SYNC,                        // Opcode fetch
        BACK,                        // Return bus to PC
        IMM0,
        IND0,
        IND1,
        IND2,
        ABS0,
        ABS1,
        ZERO,
        RDWR,                        // Extra RMW cycle
        PULL,
        PUSH,
        RTS0,
        RTS1,
        RTS2,
        JSR0,
        JSR1,
        JSR2,
        COND                         // Branch offset
    } state_t;

    // Bits [1:0] are the ABL select, bit 2 the ABL carry
    typedef enum logic [3:0] {
        AB_KEEP         = 4'd0,      // AB + 0
        AB_PC           = 4'd1,
        AB_ABS_STORE_PC = 4'd2,      // {DB, AHL + REG}, PC <= AB + 1
        AB_ZP_INDEX     = 4'd3,      // {00, DB + REG}
        AB_INC_STORE_PC = 4'd4,      // AB + 1, PC <= AB
        AB_SP_INC       = 4'd5,      // {01, SP + 1}
        AB_BRANCH       = 4'd7,
        AB_SP_KEEP_PC   = 4'd8,
        AB_SP_STORE_PC1 = 4'd9,      // {01, SP}, PC <= AB + 1
        AB_ABS_KEEP_PC  = 4'd10,
        AB_SP           = 4'd11,
        AB_INC_KEEP_PC  = 4'd12,
        AB_ABS_INC      = 4'd14,     // {DB, AHL + REG} + 1
        AB_VECTOR       = 4'd15      // {FF, REG} + 1
    } ab_mode_t;

endpackage

`default_nettype wire

// ==== logic/ctl_settings.svh ====
// Control sequencer constants for the 65C02-style core
// Word widths, register codes, fixed datapath words and opcode values
`ifndef CTL_SETTINGS_SVH
`define CTL_SETTINGS_SVH

`define CTL_DB_W      8              // Data bus and opcode
`define CTL_AB_OP_W   12             // Address-bus operation word
`define CTL_ALU_OP_W  9              // ldm, bcd, shift[2], add[3], carry[2]
`define CTL_REG_OP_W  7              // write, dst[2], src[4]
`define CTL_DO_OP_W   2              // Data-out select

`define CTL_DO_ALU    2'b00
`define CTL_DO_PCL    2'b10
`define CTL_DO_PCH    2'b11

`define CTL_DST_X     2'd0
`define CTL_DST_Y     2'd1
`define CTL_DST_A     2'd2
`define CTL_DST_S     2'd3

`define CTL_SRC_X     4'd0
`define CTL_SRC_Y     4'd1
`define CTL_SRC_S     4'd3
`define CTL_SRC_Z     4'd7

`define CTL_ALU_DEC    9'b00_00_101_00   // Minus one
`define CTL_ALU_INC    9'b00_00_100_01   // Plus one
`define CTL_ALU_LOAD_M 9'b10_00_000_00
`define CTL_ALU_ADD    9'b00_00_011_00   // Z plus M

// Branch words, taken backward and forward or not taken
`define CTL_AB_OP_BACK 12'b011_0111_11_11_1
`define CTL_AB_OP_FWD  12'b011_0110_11_11_1

`define CTL_OPC_LDA_IMM  8'hA9
`define CTL_OPC_LDX_IMM  8'hA2
`define CTL_OPC_LDY_IMM  8'hA0
`define CTL_OPC_LDA_ZP   8'hA5
`define CTL_OPC_LDA_ZPX  8'hB5
`define CTL_OPC_LDX_ZPY  8'hB6
`define CTL_OPC_LDA_ABS  8'hAD
`define CTL_OPC_LDA_ABSX 8'hBD
`define CTL_OPC_LDA_ABSY 8'hB9
`define CTL_OPC_LDA_INDX 8'hA1
`define CTL_OPC_LDA_IND  8'hB2
`define CTL_OPC_LDA_INDY 8'hB1
`define CTL_OPC_ASL_ZP   8'h06
`define CTL_OPC_ASL_ZPX  8'h16
`define CTL_OPC_JMP_ABS  8'h4C
`define CTL_OPC_JMP_IND  8'h6C
`define CTL_OPC_JMP_INDX 8'h7C
`define CTL_OPC_JSR      8'h20
`define CTL_OPC_RTS      8'h60
`define CTL_OPC_PHA      8'h48
`define CTL_OPC_PLA      8'h68
`define CTL_OPC_BRA      8'h80

`endif
